// File: include/wbc_params.svh
/*
 * Writeback/commit parameters
 * Pipe count and field widths shared across the stage
 */

`ifndef WBC_PARAMS_SVH
`define WBC_PARAMS_SVH

// Execute pipes feeding the completion port
`define WBC_NUM_PIPES 3

// Sequence number width, reorder depth is 2**WBC_SEQ_BITS
`define WBC_SEQ_BITS 3

// Architectural register index
`define WBC_ADDR_BITS 5

// Write data and pc
`define WBC_DATA_BITS 32

`endif

// File: source/wbc_pkg.sv
/*
 * Writeback/commit shared types
 * Field types for pc, data, register index and sequence number
 */

`default_nettype none

package wbc_pkg;

  `include "wbc_params.svh"

  // ----------------------------------------------------------
  // Field types
  // ----------------------------------------------------------

  // Program-order tag, wraps through the reorder space
  typedef logic [`WBC_SEQ_BITS-1:0]  seq_t;

  // Destination register index
  typedef logic [`WBC_ADDR_BITS-1:0] reg_addr_t;

  // Pc or write data
  typedef logic [`WBC_DATA_BITS-1:0] word_t;

  // ----------------------------------------------------------
  // Reorder entry state
  // ----------------------------------------------------------

  // Empty slot, or completion parked until its turn to commit
  typedef enum logic {
    ENTRY_EMPTY = 1'b0,
    ENTRY_DONE  = 1'b1
  } entry_state_e;

endpackage

`default_nettype wire

// File: source/wbc_pipe_stage.sv
/*
 * Execute pipe holding stage
 * One-entry buffer between an execute pipe and the completion arbiter
 */

`timescale 1ns/1ps
`default_nettype none

module wbc_pipe_stage
  import wbc_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // Execute side
  input  logic      in_val,
  output logic      in_rdy,
  input  word_t     in_pc,
  input  seq_t      in_seq_num,
  input  reg_addr_t in_waddr,
  input  word_t     in_wdata,
  input  logic      in_wen,

  // Arbiter side
  input  logic      grant,
  output logic      held_val,
  output word_t     held_pc,
  output seq_t      held_seq_num,
  output reg_addr_t held_waddr,
  output word_t     held_wdata,
  output logic      held_wen
);

  logic load;

  // Free slot, or the current item leaves this cycle
  assign in_rdy = !held_val || grant;
  assign load   = in_val && in_rdy;

  // Occupancy, reload wins over drain
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      held_val <= 1'b0;
    end else if (load) begin
      held_val <= 1'b1;
    end else if (grant) begin
      held_val <= 1'b0;
    end
  end

  // Payload only moves on a handshake
  always_ff @(posedge clk) begin
    if (load) begin
      held_pc      <= in_pc;
      held_seq_num <= in_seq_num;
      held_waddr   <= in_waddr;
      held_wdata   <= in_wdata;
      held_wen     <= in_wen;
    end
  end

endmodule

`default_nettype wire

// File: source/wbc_complete_arbiter.sv
/*
 * Completion arbiter
 * Round-robin pick among held pipe stages, one registered completion per cycle
 */

`timescale 1ns/1ps
`default_nettype none

`include "wbc_params.svh"

module wbc_complete_arbiter
  import wbc_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,

  // From the pipe stages
  input  logic [`WBC_NUM_PIPES-1:0] held_val,
  input  word_t                     held_pc      [`WBC_NUM_PIPES],
  input  seq_t                      held_seq_num [`WBC_NUM_PIPES],
  input  reg_addr_t                 held_waddr   [`WBC_NUM_PIPES],
  input  word_t                     held_wdata   [`WBC_NUM_PIPES],
  input  logic [`WBC_NUM_PIPES-1:0] held_wen,
  output logic [`WBC_NUM_PIPES-1:0] grant,

  // Completion notification
  output logic                      complete_val,
  output word_t                     complete_pc,
  output seq_t                      complete_seq_num,
  output reg_addr_t                 complete_waddr,
  output word_t                     complete_wdata,
  output logic                      complete_wen
);

  // Keep at least one pointer bit for a single pipe
  localparam int PTR_BITS = (`WBC_NUM_PIPES > 1) ? $clog2(`WBC_NUM_PIPES) : 1;

  logic [PTR_BITS-1:0] rr_ptr;
  logic [PTR_BITS-1:0] sel;
  logic                found;

  // ----------------------------------------------------------
  // Selection, first requester at or after the pointer
  // ----------------------------------------------------------

  always_comb begin
    int idx;
    found = 1'b0;
    sel   = '0;
    for (int i = 0; i < `WBC_NUM_PIPES; i++) begin
      idx = (int'(rr_ptr) + i) % `WBC_NUM_PIPES;
      if (!found && held_val[idx]) begin
        found = 1'b1;
        sel   = PTR_BITS'(idx);
      end
    end
  end

  // One-hot grant back to the stages
  always_comb begin
    grant = '0;
    if (found) begin
      grant[sel] = 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Registered completion and pointer update
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      complete_val <= 1'b0;
      rr_ptr       <= '0;
    end else begin
      complete_val <= found;
      if (found) begin
        // Next search starts just past the winner
        rr_ptr <= (sel == PTR_BITS'(`WBC_NUM_PIPES - 1)) ? '0 : sel + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (found) begin
      complete_pc      <= held_pc[sel];
      complete_seq_num <= held_seq_num[sel];
      complete_waddr   <= held_waddr[sel];
      complete_wdata   <= held_wdata[sel];
      complete_wen     <= held_wen[sel];
    end
  end

endmodule

`default_nettype wire

// File: source/wbc_reorder_commit.sv
/*
 * Reorder and commit
 * Parks completions by sequence number and commits them in program order
 */

`timescale 1ns/1ps
`default_nettype none

`include "wbc_params.svh"

module wbc_reorder_commit
  import wbc_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // Completion notification, always accepted
  input  logic      complete_val,
  input  word_t     complete_pc,
  input  seq_t      complete_seq_num,
  input  reg_addr_t complete_waddr,
  input  word_t     complete_wdata,
  input  logic      complete_wen,

  // Commit notification
  output logic      commit_val,
  output word_t     commit_pc,
  output seq_t      commit_seq_num,
  output reg_addr_t commit_waddr,
  output word_t     commit_wdata,
  output logic      commit_wen
);

  // One slot per sequence number
  localparam int DEPTH = 1 << `WBC_SEQ_BITS;

  // ----------------------------------------------------------
  // Entry storage
  // ----------------------------------------------------------

  entry_state_e state     [DEPTH];
  word_t        pc_mem    [DEPTH];
  reg_addr_t    waddr_mem [DEPTH];
  word_t        wdata_mem [DEPTH];
  logic         wen_mem   [DEPTH];

  // Oldest uncommitted instruction
  seq_t         commit_ptr;
  logic         head_done;

  assign head_done = (state[commit_ptr] == ENTRY_DONE);

  // Slot state, commit clears the head, completion marks its slot
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        state[i] <= ENTRY_EMPTY;
      end
    end else begin
      if (head_done) begin
        state[commit_ptr] <= ENTRY_EMPTY;
      end
      if (complete_val) begin
        state[complete_seq_num] <= ENTRY_DONE;
      end
    end
  end

  // Payload written by sequence number
  always_ff @(posedge clk) begin
    if (complete_val) begin
      pc_mem[complete_seq_num]    <= complete_pc;
      waddr_mem[complete_seq_num] <= complete_waddr;
      wdata_mem[complete_seq_num] <= complete_wdata;
      wen_mem[complete_seq_num]   <= complete_wen;
    end
  end

  // ----------------------------------------------------------
  // In-order commit
  // ----------------------------------------------------------

  // Pointer wraps through the sequence space on its own width
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      commit_val <= 1'b0;
      commit_ptr <= '0;
    end else begin
      commit_val <= head_done;
      if (head_done) begin
        commit_ptr <= commit_ptr + 1'b1;
      end
    end
  end

  // Registered commit record
  always_ff @(posedge clk) begin
    if (head_done) begin
      commit_pc      <= pc_mem[commit_ptr];
      commit_seq_num <= commit_ptr;
      commit_waddr   <= waddr_mem[commit_ptr];
      commit_wdata   <= wdata_mem[commit_ptr];
      commit_wen     <= wen_mem[commit_ptr];
    end
  end

endmodule

`default_nettype wire

// File: source/wbc_top.sv
/*
 * Writeback and commit stage
 * Pipe holding stages, completion arbiter and in-order commit
 */

`timescale 1ns/1ps
`default_nettype none

`include "wbc_params.svh"

module wbc_top
  import wbc_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,

  // Execute pipes
  input  logic [`WBC_NUM_PIPES-1:0] x_val,
  output logic [`WBC_NUM_PIPES-1:0] x_rdy,
  input  word_t                     x_pc      [`WBC_NUM_PIPES],
  input  seq_t                      x_seq_num [`WBC_NUM_PIPES],
  input  reg_addr_t                 x_waddr   [`WBC_NUM_PIPES],
  input  word_t                     x_wdata   [`WBC_NUM_PIPES],
  input  logic [`WBC_NUM_PIPES-1:0] x_wen,

  // Completion notification, pc stays internal
  output logic                      complete_val,
  output seq_t                      complete_seq_num,
  output reg_addr_t                 complete_waddr,
  output word_t                     complete_wdata,
  output logic                      complete_wen,

  // Commit notification
  output logic                      commit_val,
  output word_t                     commit_pc,
  output seq_t                      commit_seq_num,
  output reg_addr_t                 commit_waddr,
  output word_t                     commit_wdata,
  output logic                      commit_wen
);

  // ----------------------------------------------------------
  // Stage to arbiter wires
  // ----------------------------------------------------------

  logic [`WBC_NUM_PIPES-1:0] held_val;
  word_t                     held_pc      [`WBC_NUM_PIPES];
  seq_t                      held_seq_num [`WBC_NUM_PIPES];
  reg_addr_t                 held_waddr   [`WBC_NUM_PIPES];
  word_t                     held_wdata   [`WBC_NUM_PIPES];
  logic [`WBC_NUM_PIPES-1:0] held_wen;
  logic [`WBC_NUM_PIPES-1:0] grant;

  // Only the reorder block sees the completion pc
  word_t                     complete_pc;

  // One holding stage per execute pipe
  for (genvar p = 0; p < `WBC_NUM_PIPES; p++) begin : g_stage
    wbc_pipe_stage stage_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_val       (x_val[p]),
      .in_rdy       (x_rdy[p]),
      .in_pc        (x_pc[p]),
      .in_seq_num   (x_seq_num[p]),
      .in_waddr     (x_waddr[p]),
      .in_wdata     (x_wdata[p]),
      .in_wen       (x_wen[p]),
      .grant        (grant[p]),
      .held_val     (held_val[p]),
      .held_pc      (held_pc[p]),
      .held_seq_num (held_seq_num[p]),
      .held_waddr   (held_waddr[p]),
      .held_wdata   (held_wdata[p]),
      .held_wen     (held_wen[p])
    );
  end

  wbc_complete_arbiter arbiter_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .held_val         (held_val),
    .held_pc          (held_pc),
    .held_seq_num     (held_seq_num),
    .held_waddr       (held_waddr),
    .held_wdata       (held_wdata),
    .held_wen         (held_wen),
    .grant            (grant),
    .complete_val     (complete_val),
    .complete_pc      (complete_pc),
    .complete_seq_num (complete_seq_num),
    .complete_waddr   (complete_waddr),
    .complete_wdata   (complete_wdata),
    .complete_wen     (complete_wen)
  );

  wbc_reorder_commit reorder_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .complete_val     (complete_val),
    .complete_pc      (complete_pc),
    .complete_seq_num (complete_seq_num),
    .complete_waddr   (complete_waddr),
    .complete_wdata   (complete_wdata),
    .complete_wen     (complete_wen),
    .commit_val       (commit_val),
    .commit_pc        (commit_pc),
    .commit_seq_num   (commit_seq_num),
    .commit_waddr     (commit_waddr),
    .commit_wdata     (commit_wdata),
    .commit_wen       (commit_wen)
  );

endmodule

`default_nettype wire

// File: tb/wbc_tb.sv
/*
 * Writeback/commit testbench
 * Random in-order issue over the execute pipes, completion scoreboard
 * and in-order commit check against the issue log
 */

`timescale 1ns/1ps
`default_nettype none

`include "wbc_params.svh"

module wbc_tb
  import wbc_pkg::*;
();

  localparam int NUM_PIPES   = `WBC_NUM_PIPES;
  localparam int SEQ_SPAN    = 1 << `WBC_SEQ_BITS;
  localparam int NUM_INSTR   = 240;
  localparam int WATCHDOG_NS = NUM_INSTR * 8 * 40;

  // Expected commit record for one instruction
  typedef struct packed {
    word_t     pc;
    seq_t      seq_num;
    reg_addr_t waddr;
    word_t     wdata;
    logic      wen;
  } commit_rec_t;

  logic                  clk;
  logic                  rst_n;
  logic [NUM_PIPES-1:0]  x_val;
  logic [NUM_PIPES-1:0]  x_rdy;
  word_t                 x_pc      [NUM_PIPES];
  seq_t                  x_seq_num [NUM_PIPES];
  reg_addr_t             x_waddr   [NUM_PIPES];
  word_t                 x_wdata   [NUM_PIPES];
  logic [NUM_PIPES-1:0]  x_wen;
  logic                  complete_val;
  seq_t                  complete_seq_num;
  reg_addr_t             complete_waddr;
  word_t                 complete_wdata;
  logic                  complete_wen;
  logic                  commit_val;
  word_t                 commit_pc;
  seq_t                  commit_seq_num;
  reg_addr_t             commit_waddr;
  word_t                 commit_wdata;
  logic                  commit_wen;

  // Issue log in program order
  word_t     log_pc    [NUM_INSTR];
  reg_addr_t log_waddr [NUM_INSTR];
  word_t     log_wdata [NUM_INSTR];
  logic      log_wen   [NUM_INSTR];

  int   seed = 41648;
  int   issued_cnt;
  int   xfer_cnt;
  int   completed_cnt;
  int   committed_cnt;
  bit   first_xfer;
  bit   pipe_busy [NUM_PIPES];
  int   uncompleted [$];

  wbc_top wbc_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Reference and compare helpers
  // ------------------------------------------------------------

  // Seq number follows issue order modulo the reorder span
  function automatic commit_rec_t ref_commit(input int k);
    commit_rec_t rec;
    rec.pc      = log_pc[k];
    rec.seq_num = seq_t'(k % SEQ_SPAN);
    rec.waddr   = log_waddr[k];
    rec.wdata   = log_wdata[k];
    rec.wen     = log_wen[k];
    return rec;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_complete(input seq_t seq_num, input reg_addr_t waddr,
                                input word_t wdata, input logic wen,
                                input seq_t exp_seq, input reg_addr_t exp_waddr,
                                input word_t exp_wdata, input logic exp_wen);
    if (seq_num !== exp_seq || waddr !== exp_waddr || wdata !== exp_wdata ||
        wen !== exp_wen) begin
      fail_run({$sformatf("error %0t: completion seq %0d waddr %0d wdata %h wen %b,",
                          $time, seq_num, waddr, wdata, wen),
                $sformatf(" expected seq %0d waddr %0d wdata %h wen %b",
                          exp_seq, exp_waddr, exp_wdata, exp_wen)});
    end
  endtask

  task automatic check_commit(input word_t pc, input seq_t seq_num, input reg_addr_t waddr,
                              input word_t wdata, input logic wen,
                              input word_t exp_pc, input seq_t exp_seq,
                              input reg_addr_t exp_waddr, input word_t exp_wdata,
                              input logic exp_wen);
    if (pc !== exp_pc || seq_num !== exp_seq || waddr !== exp_waddr ||
        wdata !== exp_wdata || wen !== exp_wen) begin
      fail_run({$sformatf("error %0t: commit pc %h seq %0d waddr %0d wdata %h wen %b,",
                          $time, pc, seq_num, waddr, wdata, wen),
                $sformatf(" expected pc %h seq %0d waddr %0d wdata %h wen %b",
                          exp_pc, exp_seq, exp_waddr, exp_wdata, exp_wen)});
    end
  endtask

  // Log the next instruction and put it on pipe p
  task automatic issue_on(input int p);
    int k;
    k            = issued_cnt;
    log_pc[k]    = word_t'($random(seed)) & ~word_t'(3);
    log_waddr[k] = reg_addr_t'($random(seed));
    log_wdata[k] = word_t'($random(seed));
    log_wen[k]   = $random(seed) & 1;
    x_val[p]     <= 1'b1;
    x_pc[p]      <= log_pc[k];
    x_seq_num[p] <= seq_t'(k % SEQ_SPAN);
    x_waddr[p]   <= log_waddr[k];
    x_wdata[p]   <= log_wdata[k];
    x_wen[p]     <= log_wen[k];
    pipe_busy[p] = 1'b1;
    uncompleted.push_back(k);
    issued_cnt++;
  endtask

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------

  initial begin : issue_gen
    int  p;
    int  start;
    bit  burst;
    wait (rst_n === 1'b1);
    while (xfer_cnt < NUM_INSTR) begin
      @(posedge clk);
      // Pre-edge rdy tells which pending sends went through
      for (int i = 0; i < NUM_PIPES; i++) begin
        if (pipe_busy[i] && x_rdy[i]) begin
          pipe_busy[i] = 1'b0;
          first_xfer   = 1'b1;
          xfer_cnt++;
        end
      end
      // Middle stretch sends on every free pipe
      burst = (issued_cnt >= 80 && issued_cnt < 180);
      // Each pipe tried once, starting at a random one
      start = $unsigned($random(seed)) % NUM_PIPES;
      for (int a = 0; a < NUM_PIPES; a++) begin
        p = (start + a) % NUM_PIPES;
        if (!pipe_busy[p] && issued_cnt < NUM_INSTR &&
            issued_cnt - committed_cnt < SEQ_SPAN &&
            (burst || ($unsigned($random(seed)) % 3) == 0)) begin
          issue_on(p);
        end
      end
      for (int i = 0; i < NUM_PIPES; i++) begin
        if (!pipe_busy[i]) begin
          x_val[i] <= 1'b0;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Monitors
  // ------------------------------------------------------------

  always @(posedge clk) begin : monitor_out
    int          hit;
    commit_rec_t exp;
    if (rst_n === 1'b1) begin
      if (!first_xfer && (complete_val !== 1'b0 || commit_val !== 1'b0)) begin
        fail_run("Completion or commit seen before any instruction was sent");
      end
      if (complete_val === 1'b1) begin
        hit = -1;
        for (int i = 0; i < uncompleted.size(); i++) begin
          if (hit < 0 && seq_t'(uncompleted[i] % SEQ_SPAN) == complete_seq_num) begin
            hit = i;
          end
        end
        if (hit < 0) begin
          fail_run($sformatf("Completion for seq %0d matches no outstanding instruction",
                             complete_seq_num));
        end
        exp = ref_commit(uncompleted[hit]);
        check_complete(complete_seq_num, complete_waddr, complete_wdata, complete_wen,
                       exp.seq_num, exp.waddr, exp.wdata, exp.wen);
        uncompleted.delete(hit);
        completed_cnt++;
      end
      if (commit_val === 1'b1) begin
        if (committed_cnt >= completed_cnt) begin
          fail_run("Commit seen for an instruction that has not completed");
        end
        exp = ref_commit(committed_cnt);
        check_commit(commit_pc, commit_seq_num, commit_waddr, commit_wdata, commit_wen,
                     exp.pc, exp.seq_num, exp.waddr, exp.wdata, exp.wen);
        committed_cnt++;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    fail_run("Timeout waiting for all instructions to commit");
  end

  // ------------------------------------------------------------
  // Reset and end of run
  // ------------------------------------------------------------

  initial begin
    rst_n = 1'b0;
    x_val = '0;
    x_wen = '0;
    for (int i = 0; i < NUM_PIPES; i++) begin
      x_pc[i]      = '0;
      x_seq_num[i] = '0;
      x_waddr[i]   = '0;
      x_wdata[i]   = '0;
      pipe_busy[i] = 1'b0;
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    if (x_rdy !== '1) begin
      fail_run("Not every pipe is ready right after reset");
    end
    while (committed_cnt < NUM_INSTR) begin
      @(posedge clk);
    end
    // Idle tail so stray notifications would show up
    repeat (20) @(posedge clk);
    if (issued_cnt == NUM_INSTR && completed_cnt == NUM_INSTR &&
        committed_cnt == NUM_INSTR && uncompleted.size() == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      fail_run($sformatf("Counts differ: issued %0d completed %0d committed %0d",
                         issued_cnt, completed_cnt, committed_cnt));
    end
  end

endmodule

`default_nettype wire

// File: wbc.f
+incdir+include
source/wbc_pkg.sv
source/wbc_pipe_stage.sv
source/wbc_complete_arbiter.sv
source/wbc_reorder_commit.sv
source/wbc_top.sv
tb/wbc_tb.sv
